//--- hdl/fv_bank_config.svh
`ifndef FV_BANK_CONFIG_SVH
`define FV_BANK_CONFIG_SVH

// sizes of one feature-value SRAM bank

// one SRAM line, two feature values side by side
`define FV_WIDTH 64

// feature values per node at most
// two per line, so up to 8 lines per node
`define MAX_FV_NUM 16

// node groups held per replay iteration in this bank
`define NODE_PER_ITER 4

// replay iterations stored back to back in the bank
`define MAX_REPLAY_ITER 4

// node identifier range
// upper bits select the node group slot in the SRAM
`define MAX_NODE_ID 64

// edge PEs that may request a node group
`define NUM_EDGE_PE 4

`endif

//--- hdl/fv_bank_pkg.sv
`include "fv_bank_config.svh"

package fv_bank_pkg;

    // one SRAM line
    typedef logic [`FV_WIDTH-1:0] fv_data_t;

    // line within a node, and line count up to 8
    typedef logic [$clog2(`MAX_FV_NUM/2)-1:0] line_idx_t;
    typedef logic [$clog2(`MAX_FV_NUM/2):0] line_cnt_t;

    // feature values per node, 0 to 16
    typedef logic [$clog2(`MAX_FV_NUM):0] fv_num_t;

    typedef logic [$clog2(`NODE_PER_ITER)-1:0] node_grp_t;
    typedef logic [$clog2(`MAX_NODE_ID)-1:0] node_id_t;
    typedef logic [$clog2(`MAX_REPLAY_ITER)-1:0] replay_iter_t;
    typedef logic [$clog2(`NUM_EDGE_PE)-1:0] pe_tag_t;

    // stream: {iter, group, line}, request: {node_id[5:2], line}
    typedef logic [$clog2(`MAX_REPLAY_ITER)+$clog2(`NODE_PER_ITER)+
                   $clog2(`MAX_FV_NUM/2)-1:0] sram_addr_t;

    // small bank address, {group, line}
    typedef logic [$clog2(`NODE_PER_ITER)+$clog2(`MAX_FV_NUM/2)-1:0] small_addr_t;

    // SRAM port, both strobes active low
    typedef struct packed {
        logic       cen;
        logic       wen;
        sram_addr_t addr;
        fv_data_t   wdata;
    } sram_req_t;

    // client request, rd_wr high for write-back
    typedef struct packed {
        logic     valid;
        logic     rd_wr;
        logic     wr_eos;
        node_id_t node_id;
        pe_tag_t  pe_tag;
        fv_data_t data;
    } bank_req_t;

    // beat towards the small feature-value bank
    typedef struct packed {
        logic        sos;
        logic        eos;
        small_addr_t addr;
        fv_data_t    data;
    } small_beat_t;

    // beat back to the requesting edge PE
    typedef struct packed {
        logic     valid;
        logic     sos;
        logic     eos;
        pe_tag_t  pe_tag;
        fv_data_t data;
    } edge_beat_t;

    // lines per node, half the value count rounded up
    // a node always owns at least one line
    function automatic line_cnt_t fv_lines(input fv_num_t num);
        logic [$bits(fv_num_t):0] rounded;
        line_cnt_t                lines;
        rounded = {1'b0, num} + 1'b1;
        lines = line_cnt_t'(rounded >> 1);
        if (lines == '0) begin
            lines = line_cnt_t'(1);
        end
        return lines;
    endfunction

endpackage

//--- hdl/bank_arbiter.sv
`timescale 1ns/1ps

module bank_arbiter (
    input  logic                      clk,
    input  logic                      reset,
    input  fv_bank_pkg::replay_iter_t replay_iter,
    input  logic                      update_odd,
    input  logic                      stream_begin,
    input  logic                      req_valid,
    input  fv_bank_pkg::sram_req_t    stream_sram,
    input  fv_bank_pkg::sram_req_t    req_sram,
    input  logic                      stream_done,
    input  logic                      req_done,
    output logic                      stream_start,
    output logic                      req_start,
    output fv_bank_pkg::replay_iter_t stream_iter,
    output fv_bank_pkg::sram_req_t    sram
);

    typedef enum logic [1:0] {
        mode_idle,
        mode_stream,
        mode_serve
    } mode_t;

    mode_t                     mode;
    fv_bank_pkg::replay_iter_t last_iter;
    logic                      idle;
    logic                      iter_change;

    assign idle = (mode == mode_idle);
    assign iter_change = (replay_iter != last_iter);

    // odd update iterations belong to the stream, even ones to clients
    assign stream_start = idle && update_odd && (stream_begin || iter_change);
    assign req_start = idle && !update_odd && req_valid;

    // live iteration in the start cycle, stored one while streaming
    assign stream_iter = idle ? replay_iter : last_iter;

    always_ff @(posedge clk) begin
        if (reset) begin
            mode <= mode_idle;
            last_iter <= '0;
        end else begin
            case (mode)
                mode_idle: begin
                    if (stream_start) begin
                        last_iter <= replay_iter;
                        if (!stream_done) begin
                            mode <= mode_stream;
                        end
                    end else if (req_start && !req_done) begin
                        // single-line write or read ends in its start cycle
                        mode <= mode_serve;
                    end
                end
                mode_stream: begin
                    if (stream_done) begin
                        mode <= mode_idle;
                    end
                end
                mode_serve: begin
                    if (req_done) begin
                        mode <= mode_idle;
                    end
                end
                default: begin
                    mode <= mode_idle;
                end
            endcase
        end
    end

    // port mux, start cycle already routed to the starting engine
    always_comb begin
        sram.cen = 1'b1;
        sram.wen = 1'b1;
        sram.addr = '0;
        sram.wdata = '0;
        if (stream_start || (mode == mode_stream)) begin
            sram = stream_sram;
        end else if (req_start || (mode == mode_serve)) begin
            sram = req_sram;
        end
    end

    // the two engines never hold the port in the same cycle
    a_one_start: assert property (@(posedge clk) disable iff (reset)
        !(!stream_sram.cen && !req_sram.cen));

    // once an engine runs, nothing starts until it reports done
    a_start_only_idle: assert property (@(posedge clk) disable iff (reset)
        ((stream_start && !stream_done) || (req_start && !req_done)) |=>
        (!(stream_start || req_start)) until_with (stream_done || req_done));

endmodule

//--- hdl/iter_stream_engine.sv
`timescale 1ns/1ps
`include "fv_bank_config.svh"

module iter_stream_engine (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  fv_bank_pkg::replay_iter_t iter,
    input  fv_bank_pkg::fv_num_t      fv_num,
    input  fv_bank_pkg::fv_data_t     sram_rdata,
    output fv_bank_pkg::sram_req_t    sram_req,
    output logic                      done,
    output fv_bank_pkg::small_beat_t  small_out
);

    // what a read still owes its beat once the data returns
    typedef struct packed {
        logic                     valid;
        logic                     sos;
        logic                     eos;
        fv_bank_pkg::small_addr_t addr;
    } rd_meta_t;

    logic                   active;
    logic                   issue;
    fv_bank_pkg::node_grp_t grp;
    fv_bank_pkg::line_idx_t line;
    fv_bank_pkg::line_cnt_t lines;
    fv_bank_pkg::line_cnt_t cur_lines;
    logic                   last_line;
    logic                   last_grp;
    rd_meta_t               meta;

    // first read goes out in the start cycle itself
    assign issue = start || active;

    // L straight from fv_num until the latch holds it
    assign cur_lines = start ? fv_bank_pkg::fv_lines(fv_num) : lines;

    assign last_line = ((fv_bank_pkg::line_cnt_t'(line) + 1'b1) == cur_lines);
    assign last_grp = (grp == fv_bank_pkg::node_grp_t'(`NODE_PER_ITER - 1));
    assign done = issue && last_line && last_grp;

    // read only, address {iter, group, line}
    always_comb begin
        sram_req.cen = !issue;
        sram_req.wen = 1'b1;
        sram_req.addr = {iter, grp, line};
        sram_req.wdata = '0;
    end

    // counters sit at zero between streams
    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            grp <= '0;
            line <= '0;
        end else if (issue) begin
            if (done) begin
                active <= 1'b0;
                grp <= '0;
                line <= '0;
            end else begin
                active <= 1'b1;
                if (last_line) begin
                    line <= '0;
                    grp <= grp + 1'b1;
                end else begin
                    line <= line + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            lines <= fv_bank_pkg::fv_lines(fv_num);
        end
    end

    // one cycle behind the read, lines up with sram_rdata
    always_ff @(posedge clk) begin
        if (reset) begin
            meta <= '0;
        end else begin
            meta.valid <= issue;
            meta.sos <= start;
            meta.eos <= done;
            meta.addr <= {grp, line};
        end
    end

    // beat register
    // payload only loads on a returning read
    always_ff @(posedge clk) begin
        if (reset) begin
            small_out.sos <= 1'b0;
            small_out.eos <= 1'b0;
        end else begin
            small_out.sos <= meta.sos;
            small_out.eos <= meta.eos;
            if (meta.valid) begin
                small_out.addr <= meta.addr;
                small_out.data <= sram_rdata;
            end
        end
    end

    // last beat comes from the final group of a running stream
    a_eos_from_last_read: assert property (@(posedge clk) disable iff (reset)
        small_out.eos |-> $past(active, 2) &&
        (small_out.addr[$bits(fv_bank_pkg::small_addr_t)-1 -:
                        $bits(fv_bank_pkg::node_grp_t)] ==
         fv_bank_pkg::node_grp_t'(`NODE_PER_ITER - 1)));

endmodule

//--- hdl/node_request_engine.sv
`timescale 1ns/1ps

module node_request_engine (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  fv_bank_pkg::bank_req_t req,
    input  fv_bank_pkg::fv_num_t   fv_num,
    input  fv_bank_pkg::fv_data_t  sram_rdata,
    output fv_bank_pkg::sram_req_t sram_req,
    output logic                   done,
    output fv_bank_pkg::edge_beat_t edge_out
);

    typedef enum logic [1:0] {
        req_idle,
        req_write,
        req_read
    } req_state_t;

    // flags carried alongside an edge read
    typedef struct packed {
        logic valid;
        logic sos;
        logic eos;
    } rd_meta_t;

    req_state_t             state;
    fv_bank_pkg::line_idx_t line;
    fv_bank_pkg::line_cnt_t lines;
    fv_bank_pkg::line_cnt_t cur_lines;
    fv_bank_pkg::node_id_t  node_q;
    fv_bank_pkg::node_id_t  cur_node;
    fv_bank_pkg::pe_tag_t   pe_tag_q;
    logic                   wr_act;
    logic                   rd_act;
    logic                   last_rd;
    rd_meta_t               meta;

    // write-back, first beat at start then every valid beat
    assign wr_act = (start && req.rd_wr) || ((state == req_write) && req.valid);
    // edge read, one line per cycle
    assign rd_act = (start && !req.rd_wr) || (state == req_read);

    // request fields are live only in the start cycle
    assign cur_node = start ? req.node_id : node_q;
    assign cur_lines = start ? fv_bank_pkg::fv_lines(fv_num) : lines;

    assign last_rd = ((fv_bank_pkg::line_cnt_t'(line) + 1'b1) == cur_lines);

    // wr_eos ends a burst, L-th line ends a read
    assign done = (wr_act && req.wr_eos) || (rd_act && last_rd);

    // address {node_id[5:2], line}
    always_comb begin
        sram_req.cen = !(wr_act || rd_act);
        sram_req.wen = !wr_act;
        sram_req.addr = {cur_node[$bits(fv_bank_pkg::node_id_t)-1:2], line};
        sram_req.wdata = wr_act ? req.data : '0;
    end

    // shared line counter, back to zero when done
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= req_idle;
            line <= '0;
        end else if (wr_act || rd_act) begin
            if (done) begin
                state <= req_idle;
                line <= '0;
            end else begin
                line <= line + 1'b1;
                if (start) begin
                    state <= req.rd_wr ? req_write : req_read;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            node_q <= req.node_id;
            pe_tag_q <= req.pe_tag;
            lines <= fv_bank_pkg::fv_lines(fv_num);
        end
    end

    // read flags wait one cycle for the SRAM data
    always_ff @(posedge clk) begin
        if (reset) begin
            meta <= '0;
        end else begin
            meta.valid <= rd_act;
            meta.sos <= rd_act && start;
            meta.eos <= rd_act && last_rd;
        end
    end

    // beat register
    // tag still the old one here even if a new request latches
    always_ff @(posedge clk) begin
        if (reset) begin
            edge_out.valid <= 1'b0;
            edge_out.sos <= 1'b0;
            edge_out.eos <= 1'b0;
        end else begin
            edge_out.valid <= meta.valid;
            edge_out.sos <= meta.sos;
            edge_out.eos <= meta.eos;
            if (meta.valid) begin
                edge_out.pe_tag <= pe_tag_q;
                edge_out.data <= sram_rdata;
            end
        end
    end

    // requester tag fixed for the whole edge read
    a_pe_tag_stable: assert property (@(posedge clk) disable iff (reset)
        ((state == req_read) && !done) |=> $stable(pe_tag_q));

endmodule

//--- hdl/fv_bank_ctrl.sv
`timescale 1ns/1ps

module fv_bank_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  fv_bank_pkg::replay_iter_t replay_iter,
    input  logic                      update_odd,
    input  logic                      stream_begin,
    input  fv_bank_pkg::fv_num_t      fv_num,
    input  fv_bank_pkg::bank_req_t    req,
    input  fv_bank_pkg::fv_data_t     sram_rdata,
    output fv_bank_pkg::sram_req_t    sram,
    output fv_bank_pkg::small_beat_t  small_out,
    output fv_bank_pkg::edge_beat_t   edge_out
);

    // start pulses from the arbiter, done from the engines
    logic stream_start;
    logic req_start;
    logic stream_done;
    logic req_done;

    // iteration the stream engine addresses
    fv_bank_pkg::replay_iter_t stream_iter;

    // per-engine SRAM requests, muxed in the arbiter
    fv_bank_pkg::sram_req_t stream_sram;
    fv_bank_pkg::sram_req_t req_sram;

    bank_arbiter i_bank_arbiter (
        .clk          (clk),
        .reset        (reset),
        .replay_iter  (replay_iter),
        .update_odd   (update_odd),
        .stream_begin (stream_begin),
        .req_valid    (req.valid),
        .stream_sram  (stream_sram),
        .req_sram     (req_sram),
        .stream_done  (stream_done),
        .req_done     (req_done),
        .stream_start (stream_start),
        .req_start    (req_start),
        .stream_iter  (stream_iter),
        .sram         (sram)
    );

    iter_stream_engine i_iter_stream_engine (
        .clk        (clk),
        .reset      (reset),
        .start      (stream_start),
        .iter       (stream_iter),
        .fv_num     (fv_num),
        .sram_rdata (sram_rdata),
        .sram_req   (stream_sram),
        .done       (stream_done),
        .small_out  (small_out)
    );

    node_request_engine i_node_request_engine (
        .clk        (clk),
        .reset      (reset),
        .start      (req_start),
        .req        (req),
        .fv_num     (fv_num),
        .sram_rdata (sram_rdata),
        .sram_req   (req_sram),
        .done       (req_done),
        .edge_out   (edge_out)
    );

endmodule

//--- verification/fv_bank_ctrl_tb.sv
`timescale 1ns/1ps
`include "fv_bank_config.svh"

module fv_bank_ctrl_tb;

    localparam int sram_lines = 128;
    localparam int wait_limit = 40;
    // SRAM slots per node and per replay iteration
    localparam int lines_per_node = `MAX_FV_NUM / 2;
    localparam int lines_per_iter = `NODE_PER_ITER * lines_per_node;

    logic                      clk;
    logic                      reset;
    fv_bank_pkg::replay_iter_t replay_iter;
    logic                      update_odd;
    logic                      stream_begin;
    fv_bank_pkg::fv_num_t      fv_num;
    fv_bank_pkg::bank_req_t    req;
    fv_bank_pkg::fv_data_t     sram_rdata;
    fv_bank_pkg::sram_req_t    sram;
    fv_bank_pkg::small_beat_t  small_out;
    fv_bank_pkg::edge_beat_t   edge_out;

    // SRAM model contents
    fv_bank_pkg::fv_data_t sram_mem [0:sram_lines-1];
    // access and beat counts, all updated on the rising edge
    int read_count;
    int write_count;
    int edge_count;

    logic [15:0] lfsr;
    int          value_errors;
    int          timeout_errors;

    // burst data of the write-back, reused by the edge read
    fv_bank_pkg::fv_data_t wb_data [0:3];

    fv_bank_ctrl i_dut (
        .clk          (clk),
        .reset        (reset),
        .replay_iter  (replay_iter),
        .update_odd   (update_odd),
        .stream_begin (stream_begin),
        .fv_num       (fv_num),
        .req          (req),
        .sram_rdata   (sram_rdata),
        .sram         (sram),
        .small_out    (small_out),
        .edge_out     (edge_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // one cycle read latency, write lands at the edge
    always @(posedge clk) begin
        if (!reset) begin
            if (sram.cen == 1'b0 && sram.wen == 1'b1) begin
                sram_rdata <= sram_mem[sram.addr];
                read_count <= read_count + 1;
            end else if (sram.cen == 1'b0 && sram.wen == 1'b0) begin
                sram_mem[sram.addr] <= sram.wdata;
                write_count <= write_count + 1;
            end
            // edge beat seen during the cycle just ending
            if (edge_out.valid) begin
                edge_count <= edge_count + 1;
            end
        end
    end

    // 16-bit Galois LFSR, taps 16, 14, 13, 11
    function automatic logic [15:0] galois_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hb400;
        end
        return next;
    endfunction

    // one LFSR step per bit of the word
    task automatic draw_word(output fv_bank_pkg::fv_data_t word);
        int i;
        word = '0;
        for (i = 0; i < $bits(word); i++) begin
            word = {word[$bits(word)-2:0], lfsr[0]};
            lfsr = galois_step(lfsr);
        end
    endtask

    // lines per node, values rounded up to pairs
    function automatic int line_count_for(input int values);
        return (values + 1) / 2;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("error %s got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic wait_small_sos(output logic seen);
        int cycles;
        cycles = 0;
        while (small_out.sos !== 1'b1 && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        seen = (small_out.sos === 1'b1);
        assert (seen) else begin
            timeout_errors++;
            $display("timeout, no first small_out beat within %0d cycles", wait_limit);
        end
    endtask

    task automatic wait_edge_valid(output logic seen);
        int cycles;
        cycles = 0;
        while (edge_out.valid !== 1'b1 && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        seen = (edge_out.valid === 1'b1);
        assert (seen) else begin
            timeout_errors++;
            $display("timeout, no edge_out beat within %0d cycles", wait_limit);
        end
    endtask

    // back to back beats, group-major then line
    task automatic collect_stream(input int iter, input int lines);
        logic seen;
        int   beats;
        int   k;
        int   grp;
        int   line;
        beats = `NODE_PER_ITER * lines;
        wait_small_sos(seen);
        if (seen) begin
            for (k = 0; k < beats; k++) begin
                grp = k / lines;
                line = k % lines;
                check_value("small_out.addr", small_out.addr, grp * lines_per_node + line);
                check_value("small_out.data", small_out.data,
                            sram_mem[iter * lines_per_iter + grp * lines_per_node + line]);
                check_value("small_out.sos", small_out.sos, k == 0);
                check_value("small_out.eos", small_out.eos, k == beats - 1);
                @(negedge clk);
            end
            // flags gone after the last beat
            check_value("small_out.sos", small_out.sos, 1'b0);
            check_value("small_out.eos", small_out.eos, 1'b0);
        end
    endtask

    task automatic after_reset_outputs();
        check_value("sram.cen", sram.cen, 1'b1);
        check_value("sram.wen", sram.wen, 1'b1);
        check_value("small_out.sos", small_out.sos, 1'b0);
        check_value("small_out.eos", small_out.eos, 1'b0);
        check_value("edge_out.valid", edge_out.valid, 1'b0);
        check_value("edge_out.sos", edge_out.sos, 1'b0);
        check_value("edge_out.eos", edge_out.eos, 1'b0);
    endtask

    task automatic full_iteration_stream();
        int reads_before;
        reads_before = read_count;
        update_odd = 1'b1;
        replay_iter = 2'd2;
        fv_num = 5'd16;
        stream_begin = 1'b1;
        @(negedge clk);
        stream_begin = 1'b0;
        collect_stream(2, line_count_for(16));
        check_value("sram read count", read_count - reads_before, 32);
    endtask

    task automatic replay_iter_change();
        int reads_before;
        replay_iter = 2'd1;
        fv_num = 5'd5;
        @(negedge clk);
        collect_stream(1, line_count_for(5));
        // same iteration, no stream_begin, bank stays quiet
        reads_before = read_count;
        repeat (50) begin
            @(negedge clk);
            check_value("small_out.sos", small_out.sos, 1'b0);
            check_value("small_out.eos", small_out.eos, 1'b0);
        end
        check_value("sram read count", read_count - reads_before, 0);
    endtask

    task automatic write_back_burst();
        int writes_before;
        int base;
        int i;
        base = (13 >> 2) * lines_per_node;
        for (i = 0; i < 4; i++) begin
            draw_word(wb_data[i]);
        end
        writes_before = write_count;
        update_odd = 1'b0;
        req.valid = 1'b1;
        req.rd_wr = 1'b1;
        req.node_id = 6'd13;
        req.pe_tag = '0;
        for (i = 0; i < 4; i++) begin
            req.wr_eos = (i == 3);
            req.data = wb_data[i];
            @(negedge clk);
        end
        req = '0;
        @(negedge clk);
        check_value("sram write count", write_count - writes_before, 4);
        for (i = 0; i < 4; i++) begin
            check_value("sram_mem", sram_mem[base + i], wb_data[i]);
        end
    endtask

    task automatic edge_read_back();
        logic seen;
        int   edges_before;
        int   lines;
        int   k;
        lines = line_count_for(8);
        edges_before = edge_count;
        fv_num = 5'd8;
        req.valid = 1'b1;
        req.rd_wr = 1'b0;
        req.wr_eos = 1'b0;
        req.node_id = 6'd13;
        req.pe_tag = 2'd2;
        req.data = '0;
        @(negedge clk);
        req = '0;
        wait_edge_valid(seen);
        if (seen) begin
            for (k = 0; k < lines; k++) begin
                check_value("edge_out.valid", edge_out.valid, 1'b1);
                check_value("edge_out.pe_tag", edge_out.pe_tag, 2'd2);
                check_value("edge_out.data", edge_out.data, wb_data[k]);
                check_value("edge_out.sos", edge_out.sos, k == 0);
                check_value("edge_out.eos", edge_out.eos, k == lines - 1);
                @(negedge clk);
            end
            check_value("edge_out.valid", edge_out.valid, 1'b0);
        end
        check_value("edge_out beat count", edge_count - edges_before, lines);
    endtask

    task automatic request_during_stream();
        int writes_before;
        int edges_before;
        int base;
        int i;
        base = (13 >> 2) * lines_per_node;
        writes_before = write_count;
        edges_before = edge_count;
        update_odd = 1'b1;
        fv_num = 5'd4;
        stream_begin = 1'b1;
        // write-back attempt held through the whole stream
        req.valid = 1'b1;
        req.rd_wr = 1'b1;
        req.wr_eos = 1'b1;
        req.node_id = 6'd13;
        req.pe_tag = 2'd1;
        req.data = ~wb_data[0];
        @(negedge clk);
        stream_begin = 1'b0;
        collect_stream(1, line_count_for(4));
        // then an edge read attempt, still an odd iteration
        req.rd_wr = 1'b0;
        req.wr_eos = 1'b0;
        repeat (4) @(negedge clk);
        req = '0;
        @(negedge clk);
        check_value("sram write count", write_count - writes_before, 0);
        check_value("edge_out beat count", edge_count - edges_before, 0);
        for (i = 0; i < 4; i++) begin
            check_value("sram_mem", sram_mem[base + i], wb_data[i]);
        end
    endtask

    initial begin
        int a;
        reset = 1'b1;
        replay_iter = '0;
        update_odd = 1'b0;
        stream_begin = 1'b0;
        fv_num = '0;
        req = '0;
        sram_rdata = '0;
        read_count = 0;
        write_count = 0;
        edge_count = 0;
        value_errors = 0;
        timeout_errors = 0;
        lfsr = 16'd79;
        // preload every line before the first edge
        for (a = 0; a < sram_lines; a++) begin
            draw_word(sram_mem[a]);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        after_reset_outputs();
        full_iteration_stream();
        replay_iter_change();
        write_back_burst();
        edge_read_back();
        request_during_stream();
        $display("errors: value %0d, timeout %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- fv_bank_ctrl.f
+incdir+hdl
hdl/fv_bank_pkg.sv
hdl/bank_arbiter.sv
hdl/iter_stream_engine.sv
hdl/node_request_engine.sv
hdl/fv_bank_ctrl.sv
verification/fv_bank_ctrl_tb.sv

//--- Bender.yml
package:
  name: fv_bank_ctrl

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fv_bank_pkg.sv
      - hdl/bank_arbiter.sv
      - hdl/iter_stream_engine.sv
      - hdl/node_request_engine.sv
      - hdl/fv_bank_ctrl.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/fv_bank_ctrl_tb.sv
